/* Makefile */
# Verilator build and run for the serial digit beacon

VERILATOR ?= verilator
TOP       ?= tb_uart_beacon
SEED_ARGS ?= +verilator+seed+62
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

FILELIST := sources.f
SV_SRCS  := $(wildcard *.sv)
BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := All checks passed

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SV_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN) $(SEED_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* baud_tick_gen.sv */
`timescale 1ns/1ps

module baud_tick_gen (
    input  logic clk,
    input  logic rst_n,
    output logic baud_tick
);

    // free-running bit period counter
    logic [uart_beacon_pkg::tick_cnt_w-1:0] cnt_q;

    // counter at its last value this cycle
    logic wrap;

    assign wrap = (cnt_q == uart_beacon_pkg::tick_last);

    // counts 0 .. clks_per_bit-1, then reloads
    // one tick per bit period, used as a clock enable
    // by the transmitter instead of a divided clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q     <= '0;
            baud_tick <= 1'b0;
        end else begin
            // registered tick, high for the one cycle after the reload
            baud_tick <= wrap;
            if (wrap) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // tick spacing
    //   cnt_q walks 217 distinct values, so ticks are 217 clocks apart
    //   the first tick comes 217 clocks after reset release
    //   nothing stops the divider, it keeps running while the line is idle
    //
    // start bit alignment
    //   the transmitter waits for the next tick before the start edge,
    //   so the acceptance to start edge delay is 1 .. 217 clocks

endmodule

/* digit_sequencer.sv */
`timescale 1ns/1ps

module digit_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run,
    input  uart_beacon_pkg::tx_stat_t stat,
    output uart_beacon_pkg::tx_req_t  req
);

    // registered copy of run, drives the send level
    logic send_q;

    // current ascii digit offered to the transmitter
    logic [7:0] digit_q;

    // digit to load when a frame completes
    logic [7:0] digit_nxt;

    // wrap from "9" back to "0"
    always_comb begin
        if (digit_q == uart_beacon_pkg::ascii_last) begin
            digit_nxt = uart_beacon_pkg::ascii_first;
        end else begin
            digit_nxt = digit_q + 8'd1;
        end
    end

    // send follows run one cycle later
    // a low run only stops new frames, the transmitter
    // finishes a frame it has already taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            send_q <= 1'b0;
        end else begin
            send_q <= run;
        end
    end

    // advance only on done
    // busy is not looked at here, the digit is simply held
    // for as long as the transmitter needs it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit_q <= uart_beacon_pkg::ascii_first;
        end else if (stat.done) begin
            digit_q <= digit_nxt;
        end
    end

    // digit changes in the cycle after the done pulse;
    // the transmitter skips acceptance during that pulse,
    // so it always latches the new digit, never the old one again
    //
    // a frame that ends while run is low still advances the digit,
    // so the stream resumes with the next character after a pause

    // request to the transmitter
    assign req = '{
        data: digit_q,
        send: send_q
    };

endmodule

/* sources.f */
uart_beacon_pkg.sv
baud_tick_gen.sv
digit_sequencer.sv
uart_tx_8n1.sv
uart_beacon_top.sv
uart_beacon_checker.sv
tb_uart_beacon.sv

/* tb_uart_beacon.sv */
`timescale 1ns/1ps

module tb_uart_beacon;

    // one stimulus row: run level and frames to collect
    typedef struct packed {
        logic       run_lvl;
        logic [1:0] frames;
    } stim_row_t;

    logic clk;
    logic rst_n;
    logic run;
    logic tx;

    // low rows with frames > 0 drop run just after the last start edge
    stim_row_t stim_tab [16] = '{
        '{run_lvl: 1'b0, frames: 2'd0},
        '{run_lvl: 1'b1, frames: 2'd3},
        '{run_lvl: 1'b1, frames: 2'd2},
        '{run_lvl: 1'b0, frames: 2'd1},
        '{run_lvl: 1'b1, frames: 2'd1},
        '{run_lvl: 1'b0, frames: 2'd0},
        '{run_lvl: 1'b1, frames: 2'd3},
        '{run_lvl: 1'b1, frames: 2'd3},
        '{run_lvl: 1'b0, frames: 2'd1},
        '{run_lvl: 1'b1, frames: 2'd2},
        '{run_lvl: 1'b0, frames: 2'd0},
        '{run_lvl: 1'b1, frames: 2'd1},
        '{run_lvl: 1'b1, frames: 2'd3},
        '{run_lvl: 1'b0, frames: 2'd1},
        '{run_lvl: 1'b1, frames: 2'd2},
        '{run_lvl: 1'b0, frames: 2'd0}
    };

    int         cyc = 0;
    int         limit_cycles = 0;
    int         checks = 0;
    int         errors = 0;
    // reference model, next expected character
    logic [7:0] exp_char;
    // gap check armed only while run stayed high since the last frame
    logic       gap_valid;
    int         last_stop_end;

    uart_beacon_top u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .tx    (tx)
    );

    // 8 ns period
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // first falling clock edge that sees the start bit
    task automatic wait_start(output int t0);
        do begin
            @(negedge clk);
        end while (tx !== 1'b0);
        t0 = cyc;
    endtask

    // decode one frame, check framing, edge spacing and data
    task automatic decode_frame(input logic drop_run);
        int         t0;
        int         k;
        int         rem;
        int         dev;
        int         gap;
        int         half;
        logic       prev;
        logic [9:0] bits;
        logic [7:0] got;
        half = uart_beacon_pkg::clks_per_bit / 2;
        bits = '0;
        wait_start(t0);
        if (gap_valid) begin
            // stop end to next start edge, at most one bit period plus one
            gap = t0 - last_stop_end;
            check("frame_gap", gap, (gap > uart_beacon_pkg::clks_per_bit + 1) ?
                  uart_beacon_pkg::clks_per_bit + 1 : gap);
        end
        if (drop_run) begin
            // pause while the frame is on the line
            run = 1'b0;
        end
        prev = 1'b0;
        for (k = 1; k < uart_beacon_pkg::frame_bits * uart_beacon_pkg::clks_per_bit; k++) begin
            @(negedge clk);
            if (tx !== prev) begin
                // edges only on bit boundaries, within one clock
                rem = k % uart_beacon_pkg::clks_per_bit;
                dev = (rem > half) ? uart_beacon_pkg::clks_per_bit - rem : rem;
                check("bit_edge_offset", dev, (dev > 1) ? 1 : dev);
                prev = tx;
            end
            // mid-bit samples, lsb first into the low end
            if (k >= half && ((k - half) % uart_beacon_pkg::clks_per_bit) == 0) begin
                bits = {tx, bits[9:1]};
            end
        end
        got = bits[8:1];
        check("start_bit", 32'(bits[0]), 32'd0);
        check("stop_bit", 32'(bits[9]), 32'd1);
        check("tx_data", 32'(got), 32'(exp_char));
        exp_char = (exp_char == uart_beacon_pkg::ascii_last) ?
                   uart_beacon_pkg::ascii_first : exp_char + 8'd1;
        last_stop_end = t0 + uart_beacon_pkg::frame_bits * uart_beacon_pkg::clks_per_bit;
        gap_valid = run;
    endtask

    // run low, line must stay high for three frame times
    task automatic watch_idle();
        int low_cnt;
        low_cnt = 0;
        repeat (3 * uart_beacon_pkg::frame_bits * uart_beacon_pkg::clks_per_bit) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                low_cnt++;
            end
        end
        check("tx_low_cycles_paused", low_cnt, 0);
    endtask

    task automatic apply_row(input stim_row_t row);
        int f;
        int gap_clks;
        if (row.run_lvl) begin
            if (!run) begin
                // random idle gap before run rises again
                gap_clks = $urandom % 301;
                repeat (gap_clks) @(negedge clk);
                run = 1'b1;
                gap_valid = 1'b0;
            end
            for (f = 0; f < int'(row.frames); f++) begin
                decode_frame(1'b0);
            end
        end else begin
            for (f = 0; f < int'(row.frames); f++) begin
                decode_frame(f == int'(row.frames) - 1);
            end
            run = 1'b0;
            gap_valid = 1'b0;
            watch_idle();
        end
    endtask

    initial begin
        int n_frames;
        int n_idle;
        int r;
        clk = 1'b0;
        rst_n = 1'b0;
        run = 1'b0;
        void'($urandom(62));
        exp_char = uart_beacon_pkg::ascii_first;
        gap_valid = 1'b0;
        last_stop_end = 0;
        n_frames = 0;
        n_idle = 0;
        for (r = 0; r < 16; r++) begin
            n_frames += int'(stim_tab[r].frames);
            if (!stim_tab[r].run_lvl) begin
                n_idle++;
            end
        end
        limit_cycles = (n_frames + n_idle) * 3 * uart_beacon_pkg::frame_bits *
                       uart_beacon_pkg::clks_per_bit + 10_000;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check("tx_after_reset", 32'(tx), 32'd1);
        for (r = 0; r < 16; r++) begin
            apply_row(stim_tab[r]);
        end
        finish_run();
    end

    // cycle limit from the table length
    initial begin
        wait (limit_cycles > 0);
        wait (cyc >= limit_cycles);
        $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
        errors++;
        finish_run();
    end

endmodule

/* uart_beacon_checker.sv */
`timescale 1ns/1ps

module uart_beacon_checker (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      tx,
    input uart_beacon_pkg::tx_req_t  req,
    input uart_beacon_pkg::tx_stat_t stat
);

    // consecutive busy cycles before the current one
    int busy_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= 0;
        end else if (stat.busy) begin
            busy_cnt <= busy_cnt + 1;
        end else begin
            busy_cnt <= 0;
        end
    end

    // line idles high between frames
    a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !stat.busy |-> tx)
        else $error("tx low while the transmitter is idle");

    // done is a single cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        stat.done |=> !stat.done)
        else $error("done high for two cycles in a row");

    // only ascii digits on offer
    a_digit_range: assert property (@(posedge clk) disable iff (!rst_n)
        (req.data >= uart_beacon_pkg::ascii_first) && (req.data <= uart_beacon_pkg::ascii_last))
        else $error("req.data outside the digit range");

    // payload held while a frame is in flight
    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        stat.busy |=> $stable(req.data))
        else $error("req.data changed while busy");

    // alignment wait plus one full frame, no longer
    a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
        stat.busy |-> busy_cnt < (uart_beacon_pkg::frame_bits + 1) * uart_beacon_pkg::clks_per_bit)
        else $error("transmitter busy longer than one frame");

endmodule

bind uart_beacon_top uart_beacon_checker u_checker (
    .clk   (clk),
    .rst_n (rst_n),
    .tx    (tx),
    .req   (req),
    .stat  (stat)
);

/* uart_beacon_pkg.sv */
package uart_beacon_pkg;

    // system clock, 25 MHz board oscillator
    localparam int clk_freq_hz = 25_000_000;

    // serial line rate
    localparam int baud_rate = 115_200;

    // clocks per bit period, rounded to nearest
    // 25e6 / 115200 = 217.01 -> 217
    localparam int clks_per_bit = (clk_freq_hz + baud_rate / 2) / baud_rate;

    // divider counter width, holds 0 .. clks_per_bit-1
    localparam int tick_cnt_w = 8;

    // last divider count before reload
    localparam logic [tick_cnt_w-1:0] tick_last = tick_cnt_w'(clks_per_bit - 1);

    // ascii digit range of the beacon
    localparam logic [7:0] ascii_first = 8'h30;
    localparam logic [7:0] ascii_last  = 8'h39;

    // 8n1 frame: start, eight data bits, stop
    localparam int frame_bits = 10;

    // bit index counter inside a frame
    localparam int bit_cnt_w = $clog2(frame_bits);

    // index of the stop bit period
    localparam logic [bit_cnt_w-1:0] stop_idx = bit_cnt_w'(frame_bits - 1);

    // sequencer to transmitter
    // send is a level, data held stable while send is high
    typedef struct packed {
        logic [7:0] data;
        logic       send;
    } tx_req_t;

    // transmitter back to sequencer
    // done is a one-cycle pulse at the end of the stop bit
    typedef struct packed {
        logic busy;
        logic done;
    } tx_stat_t;

endpackage

/* uart_beacon_top.sv */
`timescale 1ns/1ps

module uart_beacon_top (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic tx
);

    // bit period enable from the divider
    logic baud_tick;

    // digit and send level toward the transmitter
    uart_beacon_pkg::tx_req_t req;

    // busy and done back to the sequencer
    uart_beacon_pkg::tx_stat_t stat;

    // baud tick generator, runs beside the pipeline
    baud_tick_gen u_tick (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud_tick (baud_tick)
    );

    // stage one
    // offers "0" .. "9" in turn while run is high
    digit_sequencer u_seq (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .stat  (stat),
        .req   (req)
    );

    // stage two
    // 8n1 serializer, one frame in flight at a time
    uart_tx_8n1 u_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud_tick (baud_tick),
        .req       (req),
        .stat      (stat),
        .tx        (tx)
    );

    // frame to frame flow with run held high
    //   done pulses at the stop bit's closing tick
    //   digit advances on the next edge
    //   transmitter takes the new digit the cycle after that
    //   start edge follows on the next tick, 217 clocks after the stop end
    //
    // with run low the current frame still finishes,
    // the digit advances, and the line then stays high

endmodule

/* uart_tx_8n1.sv */
`timescale 1ns/1ps

module uart_tx_8n1 (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      baud_tick,
    input  uart_beacon_pkg::tx_req_t  req,
    output uart_beacon_pkg::tx_stat_t stat,
    output logic                      tx
);

    // frame states
    //   st_idle       line high, waiting for send
    //   st_wait_tick  byte latched, waiting to align to a bit boundary
    //   st_start      start bit on the line
    //   st_data       data bits, lsb first
    //   st_stop       stop bit on the line
    typedef enum logic [2:0] {
        st_idle,
        st_wait_tick,
        st_start,
        st_data,
        st_stop
    } tx_state_e;

    tx_state_e state_q;

    // byte being shifted out
    logic [7:0] shift_q;

    // index of the current bit period, 0 = start, stop_idx = stop
    logic [uart_beacon_pkg::bit_cnt_w-1:0] bit_cnt_q;
    logic [uart_beacon_pkg::bit_cnt_w-1:0] bit_nxt;

    // end of frame pulse
    logic done_q;

    // line driver register, keeps tx glitch free
    logic tx_q;

    // take a byte when idle and asked to send
    // not during the done cycle, the sequencer swaps its digit then
    logic accept;

    // a bit boundary inside start or data
    logic shift_en;

    assign accept   = (state_q == st_idle) && req.send && !done_q;
    assign shift_en = baud_tick && ((state_q == st_start) || (state_q == st_data));
    assign bit_nxt  = bit_cnt_q + 1'b1;

    // frame control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            bit_cnt_q <= '0;
            done_q    <= 1'b0;
            tx_q      <= 1'b1;
        end else begin
            // done is a single cycle pulse
            done_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        state_q <= st_wait_tick;
                    end
                end
                st_wait_tick: begin
                    // start edge lands on the next tick
                    if (baud_tick) begin
                        state_q   <= st_start;
                        bit_cnt_q <= '0;
                        tx_q      <= 1'b0;
                    end
                end
                st_start, st_data: begin
                    if (baud_tick) begin
                        bit_cnt_q <= bit_nxt;
                        if (bit_nxt == uart_beacon_pkg::stop_idx) begin
                            state_q <= st_stop;
                            tx_q    <= 1'b1;
                        end else begin
                            state_q <= st_data;
                            tx_q    <= shift_q[0];
                        end
                    end
                end
                st_stop: begin
                    // stop bit over, busy drops with done
                    if (baud_tick) begin
                        state_q <= st_idle;
                        done_q  <= 1'b1;
                    end
                end
                default: begin
                    state_q <= st_idle;
                    tx_q    <= 1'b1;
                end
            endcase
        end
    end

    // payload, lsb leaves first
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= req.data;
        end else if (shift_en) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign stat = '{
        busy: (state_q != st_idle),
        done: done_q
    };

    assign tx = tx_q;

endmodule
